//--- hdl/slice_config.svh
// Slice count, counter width, data width, queue depth and downstream credits.
`ifndef SLICE_CONFIG_SVH
`define SLICE_CONFIG_SVH

// *********************************************************************
// Slice timing
// *********************************************************************

// Number of slices, one transmit queue each.
`define SLICE_NUM 4

// Width of the tick counters and period/window registers.
`define SLICE_CNT_W 20

// *********************************************************************
// Data path
// *********************************************************************

`define SLICE_DATA_W 16

// Entries per queue, equal to the upstream credits per writer.
`define SLICE_QUEUE_DEPTH 4

// Downstream credits held after reset.
`define SLICE_TX_CREDITS 2

`endif

//--- hdl/slice_pkg.sv
// Register field and arbiter state enums, register-write and frame structs.
`default_nettype none

`include "slice_config.svh"

package slice_pkg;

  // *******************************************************************
  // Register write
  // *******************************************************************

  typedef enum logic [1:0] {
    CFG_TOTAL = 2'd0,  // Slice period.
    CFG_START = 2'd1,  // Window start.
    CFG_END   = 2'd2   // Window end.
  } cfg_field_e;

  typedef struct packed {
    logic                    wr;
    cfg_field_e              field;
    logic [1:0]              idx;
    logic [`SLICE_CNT_W-1:0] value;
  } slice_cfg_t;

  // *******************************************************************
  // Transmit path
  // *******************************************************************

  typedef struct packed {
    logic [1:0]               qid;   // Source queue.
    logic [`SLICE_DATA_W-1:0] data;
  } tx_frame_t;

  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_SEND = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

//--- hdl/slice_timer.sv
// Per-slice period and window registers, tick counters and window enables.
`timescale 1ns/1ps
`default_nettype none

`include "slice_config.svh"

module slice_timer (
  input  wire logic                 clk,
  input  wire logic                 rstn,
  input  wire logic                 tsf_tick,
  input  wire slice_pkg::slice_cfg_t cfg,
  output logic                      cycle_start,
  output logic [`SLICE_NUM-1:0]     slice_en
);

  import slice_pkg::*;

  logic [`SLICE_CNT_W-1:0] total_q [`SLICE_NUM];
  logic [`SLICE_CNT_W-1:0] start_q [`SLICE_NUM];
  logic [`SLICE_CNT_W-1:0] end_q   [`SLICE_NUM];
  logic [`SLICE_CNT_W-1:0] cnt_q   [`SLICE_NUM];

  // *******************************************************************
  // Configuration registers
  // *******************************************************************

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < `SLICE_NUM; i++) begin
        total_q[i] <= '0;
        start_q[i] <= '0;
        end_q[i]   <= '0;
      end
    end else if (cfg.wr) begin
      case (cfg.field)
        CFG_TOTAL: total_q[cfg.idx] <= cfg.value;
        CFG_START: start_q[cfg.idx] <= cfg.value;
        CFG_END:   end_q[cfg.idx]   <= cfg.value;
        default:   ;  // Unused opcode.
      endcase
    end
  end

  // *******************************************************************
  // Counters and window enables
  // *******************************************************************

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < `SLICE_NUM; i++) begin
        cnt_q[i] <= '0;
      end
      slice_en <= '1;  // All windows open out of reset.
    end else begin
      for (int i = 0; i < `SLICE_NUM; i++) begin
        if (tsf_tick) begin
          cnt_q[i] <= (cnt_q[i] == total_q[i]) ? '0 : cnt_q[i] + 1'b1;
        end
        slice_en[i] <= (cnt_q[i] >= start_q[i]) && (cnt_q[i] <= end_q[i]);
      end
    end
  end

  // Slice 0 marks the start of the schedule.
  assign cycle_start = (cnt_q[0] == total_q[0]);

  // A counter can only pass its period right after a smaller period is written.
  for (genvar g = 0; g < `SLICE_NUM; g++) begin : g_chk
    a_cnt_in_period: assert property (
      @(posedge clk) disable iff (!rstn)
      (cnt_q[g] > total_q[g]) |->
        ($past(cnt_q[g] > total_q[g]) ||
         $past(cfg.wr && (cfg.field == CFG_TOTAL) && (cfg.idx == g)))
    ) else $error("slice %0d counter passed its period", g);
  end

endmodule

`default_nettype wire

//--- hdl/tx_queue.sv
// Per-slice frame FIFO that returns one upstream credit per popped entry.
`timescale 1ns/1ps
`default_nettype none

`include "slice_config.svh"

module tx_queue (
  input  wire logic                     clk,
  input  wire logic                     rstn,
  input  wire logic [1:0]               qid,
  input  wire logic                     in_valid,
  input  wire logic [`SLICE_DATA_W-1:0] in_data,
  output logic                          in_credit,
  input  wire logic                     pop,
  output logic                          empty,
  output slice_pkg::tx_frame_t          head
);

  localparam int PTR_W = $clog2(`SLICE_QUEUE_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`SLICE_QUEUE_DEPTH - 1);

  logic [`SLICE_DATA_W-1:0] mem [`SLICE_QUEUE_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W:0]           count;
  logic                     full;

  assign empty = (count == '0);
  assign full  = (count == (PTR_W+1)'(`SLICE_QUEUE_DEPTH));

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      in_credit <= pop;  // Slot freed, hand the credit back.
    end
  end

  assign head = '{qid: qid, data: mem[rd_ptr]};

  // Writer ran past its credits.
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rstn) in_valid |-> !full
  ) else $error("queue %0d pushed while full", qid);

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rstn) pop |-> !empty
  ) else $error("queue %0d popped while empty", qid);

endmodule

`default_nettype wire

//--- hdl/tx_arbiter.sv
// Round-robin transmit arbiter with downstream credit tracking and frame register.
`timescale 1ns/1ps
`default_nettype none

`include "slice_config.svh"

module tx_arbiter (
  input  wire logic                                   clk,
  input  wire logic                                   rstn,
  input  wire logic [`SLICE_NUM-1:0]                  slice_en,
  input  wire logic [`SLICE_NUM-1:0]                  empty,
  input  wire slice_pkg::tx_frame_t [`SLICE_NUM-1:0]  head,
  output logic [`SLICE_NUM-1:0]                       pop,
  output logic                                        out_valid,
  output slice_pkg::tx_frame_t                        out_frame,
  input  wire logic                                   out_credit
);

  import slice_pkg::*;

  localparam int CRD_W = $clog2(`SLICE_TX_CREDITS + 1);

  arb_state_e             state_q;
  logic [1:0]             last_q;
  logic [CRD_W-1:0]       credits_q;
  logic [`SLICE_NUM-1:0]  cand;
  logic [1:0]             sel;
  logic                   found;
  logic                   grant;

  assign cand = slice_en & ~empty;

  // *******************************************************************
  // Round-robin pick
  // *******************************************************************

  always_comb begin
    logic [1:0] idx;
    sel   = last_q;
    found = 1'b0;
    for (int k = 1; k <= `SLICE_NUM; k++) begin
      idx = last_q + k[1:0];  // Wraps modulo four.
      if (!found && cand[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
  end

  assign grant = (state_q == ARB_IDLE) && found && (credits_q != '0);

  always_comb begin
    pop = '0;
    if (grant) begin
      pop[sel] = 1'b1;
    end
  end

  // *******************************************************************
  // State, credits and output register
  // *******************************************************************

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q   <= ARB_IDLE;
      last_q    <= '1;  // First scan starts at queue 0.
      credits_q <= CRD_W'(`SLICE_TX_CREDITS);
    end else begin
      case (state_q)
        ARB_IDLE: if (grant) state_q <= ARB_SEND;
        ARB_SEND: state_q <= ARB_IDLE;
        default:  state_q <= ARB_IDLE;
      endcase
      if (grant) begin
        last_q <= sel;
      end
      case ({grant, out_credit})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: ;  // Spend and return cancel.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      out_frame <= head[sel];
    end
  end

  assign out_valid = (state_q == ARB_SEND);

  a_pop_onehot: assert property (
    @(posedge clk) disable iff (!rstn) $onehot0(pop) && ((pop & ~cand) == '0)
  ) else $error("pop is not one-hot on a candidate queue");

  // Consumer returned more credits than it was given.
  a_credit_max: assert property (
    @(posedge clk) disable iff (!rstn) credits_q <= `SLICE_TX_CREDITS
  ) else $error("downstream credits over limit");

endmodule

`default_nettype wire

//--- hdl/slice_tx_top.sv
// Top level of the time-sliced transmit scheduler with timer, queues and arbiter.
`timescale 1ns/1ps
`default_nettype none

`include "slice_config.svh"

module slice_tx_top (
  input  wire logic                                        clk,
  input  wire logic                                        rstn,
  input  wire logic                                        tsf_tick,
  input  wire slice_pkg::slice_cfg_t                       cfg,
  output logic                                             cycle_start,
  input  wire logic [`SLICE_NUM-1:0]                       in_valid,
  input  wire logic [`SLICE_NUM-1:0][`SLICE_DATA_W-1:0]    in_data,
  output logic [`SLICE_NUM-1:0]                            in_credit,
  output logic                                             out_valid,
  output slice_pkg::tx_frame_t                             out_frame,
  input  wire logic                                        out_credit
);

  import slice_pkg::*;

  logic [`SLICE_NUM-1:0]             slice_en;
  logic [`SLICE_NUM-1:0]             empty;
  logic [`SLICE_NUM-1:0]             pop;
  tx_frame_t [`SLICE_NUM-1:0]        head;

  slice_timer slice_timer_i (
    .clk         (clk),
    .rstn        (rstn),
    .tsf_tick    (tsf_tick),
    .cfg         (cfg),
    .cycle_start (cycle_start),
    .slice_en    (slice_en)
  );

  // One queue per slice.
  for (genvar g = 0; g < `SLICE_NUM; g++) begin : g_queue
    tx_queue tx_queue_i (
      .clk       (clk),
      .rstn      (rstn),
      .qid       (2'(g)),
      .in_valid  (in_valid[g]),
      .in_data   (in_data[g]),
      .in_credit (in_credit[g]),
      .pop       (pop[g]),
      .empty     (empty[g]),
      .head      (head[g])
    );
  end

  tx_arbiter tx_arbiter_i (
    .clk        (clk),
    .rstn       (rstn),
    .slice_en   (slice_en),
    .empty      (empty),
    .head       (head),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_frame  (out_frame),
    .out_credit (out_credit)
  );

endmodule

`default_nettype wire

//--- verif/slice_tx_tb.sv
// Testbench for the slice transmit scheduler with timer model and frame scoreboard.
`timescale 1ns/1ps
`default_nettype none

`include "slice_config.svh"

module slice_tx_tb;

  import slice_pkg::*;

  localparam int CYCLE_LIMIT = 4000;  // Sum of the test lengths with margin.
  localparam int DEPTH = `SLICE_QUEUE_DEPTH;

  logic clk, rstn, tsf_tick, cycle_start, out_valid, out_credit;
  slice_cfg_t cfg;
  logic [`SLICE_NUM-1:0] in_valid, in_credit;
  logic [`SLICE_NUM-1:0][`SLICE_DATA_W-1:0] in_data;
  tx_frame_t out_frame;

  logic [`SLICE_CNT_W-1:0] cnt_m [`SLICE_NUM], cnt_d1 [`SLICE_NUM], cnt_d2 [`SLICE_NUM];
  logic [`SLICE_CNT_W-1:0] tot_m [`SLICE_NUM], start_m [`SLICE_NUM], end_m [`SLICE_NUM];
  logic [`SLICE_DATA_W-1:0] exp_q [`SLICE_NUM][$];
  int wr_credit [`SLICE_NUM], send_left [`SLICE_NUM], push_cnt [`SLICE_NUM];
  int out_cnt [`SLICE_NUM], crd_cnt [`SLICE_NUM];
  int errors, cycles, pend_ret, ret_wait, held_outs;
  bit hold, tick_on;
  string test_name;

  slice_tx_top slice_tx_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // *******************************************************************
  // Timer reference model
  // *******************************************************************

  function automatic logic [`SLICE_CNT_W-1:0] next_count(
    input logic [`SLICE_CNT_W-1:0] cnt, input logic [`SLICE_CNT_W-1:0] total, input logic tick);
    if (!tick) return cnt;
    return (cnt == total) ? '0 : cnt + 1'b1;
  endfunction

  function automatic bit in_window(input logic [`SLICE_CNT_W-1:0] cnt,
    input logic [`SLICE_CNT_W-1:0] lo, input logic [`SLICE_CNT_W-1:0] hi);
    return (cnt >= lo) && (cnt <= hi);
  endfunction

  always @(posedge clk) begin
    cycles++;
    for (int i = 0; i < `SLICE_NUM; i++) begin
      if (!rstn) begin
        {cnt_m[i], cnt_d1[i], cnt_d2[i]} = '0;
        {tot_m[i], start_m[i], end_m[i]} = '0;
      end else begin
        cnt_d2[i] = cnt_d1[i];
        cnt_d1[i] = cnt_m[i];
        cnt_m[i] = next_count(cnt_m[i], tot_m[i], tsf_tick);
      end
    end
    if (rstn && cfg.wr) begin
      case (cfg.field)
        CFG_TOTAL: tot_m[cfg.idx] = cfg.value;
        CFG_START: start_m[cfg.idx] = cfg.value;
        default:   end_m[cfg.idx] = cfg.value;
      endcase
    end
  end

  initial begin
    wait (cycles >= CYCLE_LIMIT);
    $display("Run stopped after %0d cycles without finishing the tests", cycles);
    $display("TB FAILED");
    $finish;
  end

  // *******************************************************************
  // Compare, consumer, writers and ticks
  // *******************************************************************

  always @(negedge clk) begin
    logic [`SLICE_DATA_W-1:0] exp_data;
    int q;
    in_valid = '0;
    out_credit = 1'b0;
    if (rstn) begin
      for (int i = 0; i < `SLICE_NUM; i++) begin
        wr_credit[i] += in_credit[i];
        crd_cnt[i] += in_credit[i];
        assert (wr_credit[i] <= DEPTH) else begin
          errors++;
          $display("Queue %0d returned more upstream credits than its depth", i);
        end
      end
      if (out_valid) begin
        q = out_frame.qid;
        out_cnt[q]++;
        pend_ret++;
        held_outs += hold;
        if (exp_q[q].size() == 0) begin
          errors++;
          $display("Queue %0d sent a frame that was never pushed", q);
        end else begin
          exp_data = exp_q[q].pop_front();
          assert (out_frame.data == exp_data) else begin
            errors++;
            $display("[ERROR] %s: q%0d data expected %h, actual %h",
                     test_name, q, exp_data, out_frame.data);
          end
        end
        assert (in_window(cnt_d2[q], start_m[q], end_m[q])) else begin
          errors++;
          $display("Queue %0d sent at counter %0d, outside its window", q, cnt_d2[q]);
        end
      end
      assert (cycle_start == (cnt_m[0] == tot_m[0])) else begin
        errors++;
        $display("[ERROR] %s: cycle_start expected %0b, actual %0b",
                 test_name, cnt_m[0] == tot_m[0], cycle_start);
      end
      if (!hold && pend_ret > 0) begin
        if (ret_wait == 0) begin
          out_credit = 1'b1;
          pend_ret--;
          ret_wait = $urandom_range(3, 0);
        end else begin
          ret_wait--;
        end
      end
      for (int i = 0; i < `SLICE_NUM; i++) begin
        if (send_left[i] > 0 && wr_credit[i] > 0 && $urandom_range(1, 0) == 1) begin
          in_valid[i] = 1'b1;
          in_data[i] = `SLICE_DATA_W'($urandom);
          exp_q[i].push_back(in_data[i]);
          wr_credit[i]--;
          send_left[i]--;
          push_cnt[i]++;
        end
      end
      tsf_tick = tick_on && !tsf_tick && ($urandom_range(2, 0) == 0);  // Never two in a row.
    end
  end

  task automatic write_cfg(input cfg_field_e sel_field, input int slice,
                           input logic [`SLICE_CNT_W-1:0] val);
    @(negedge clk);
    cfg = '{wr: 1'b1, field: sel_field, idx: 2'(slice), value: val};
    @(negedge clk);
    cfg.wr = 1'b0;
  endtask

  task automatic send_all(input int n);
    for (int i = 0; i < `SLICE_NUM; i++) send_left[i] = n;
  endtask

  // Waits until every pushed frame is out and every credit is back.
  task automatic wait_drain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = (pend_ret != 0) || out_valid;
      for (int i = 0; i < `SLICE_NUM; i++) begin
        busy |= (send_left[i] != 0) || (exp_q[i].size() != 0);
      end
    end
  endtask

  initial begin
    void'($urandom(19));
    {rstn, tsf_tick, out_credit, hold, tick_on} = '0;
    cfg = '0;
    in_valid = '0;
    in_data = '0;
    for (int i = 0; i < `SLICE_NUM; i++) begin
      wr_credit[i] = DEPTH;
      {send_left[i], push_cnt[i], out_cnt[i], crd_cnt[i]} = '0;
    end
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    test_name = "reset";
    @(negedge clk);
    assert (!out_valid && in_credit == '0) else begin
      errors++;
      $display("[ERROR] %s: out_valid/in_credit expected 0/0, actual %0b/%h",
               test_name, out_valid, in_credit);
    end
    send_all(3);
    wait_drain();
    test_name = "order";
    send_all(12);
    wait_drain();
    test_name = "window";
    for (int i = 0; i < `SLICE_NUM; i++) begin
      write_cfg(CFG_TOTAL, i, 20'(5 + 2 * i));
      write_cfg(CFG_START, i, 20'(i + 1));
      write_cfg(CFG_END, i, 20'(i + 3));
    end
    tick_on = 1'b1;
    send_all(8);
    wait_drain();
    tick_on = 1'b0;
    test_name = "backpressure";
    for (int i = 0; i < `SLICE_NUM; i++) begin
      write_cfg(CFG_START, i, '0);
      write_cfg(CFG_END, i, '1);
    end
    held_outs = 0;
    hold = 1'b1;
    send_all(3);
    repeat (30) @(negedge clk);
    assert (held_outs <= `SLICE_TX_CREDITS) else begin
      errors++;
      $display("[ERROR] %s: frames expected <= %0d, actual %0d",
               test_name, `SLICE_TX_CREDITS, held_outs);
    end
    hold = 1'b0;
    wait_drain();
    test_name = "credits";
    for (int i = 0; i < `SLICE_NUM; i++) begin
      assert (crd_cnt[i] == out_cnt[i] && out_cnt[i] == push_cnt[i]) else begin
        errors++;
        $display("[ERROR] %s: q%0d pops expected %0d, actual %0d, credits %0d",
                 test_name, i, push_cnt[i], out_cnt[i], crd_cnt[i]);
      end
    end
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/slice_pkg.sv
hdl/slice_timer.sv
hdl/tx_queue.sv
hdl/tx_arbiter.sv
hdl/slice_tx_top.sv
verif/slice_tx_tb.sv

//--- Bender.yml
package:
  name: slice_tx

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/slice_pkg.sv
      - hdl/slice_timer.sv
      - hdl/tx_queue.sv
      - hdl/tx_arbiter.sv
      - hdl/slice_tx_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/slice_tx_tb.sv
